// ==== all.f ====
hw/pe_cfg_pkg.sv
hw/pe_types_pkg.sv
hw/weight_if.sv
hw/weight_store.sv
hw/channel_mac.sv
hw/acc_fifo.sv
hw/dequant_stage.sv
hw/conv_pe_top.sv
tests/tb_clock_gen.sv
tests/conv_pe_tb.sv

// ==== hw/acc_fifo.sv ====
`timescale 1ns/10ps

module acc_fifo (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_valid,
    output logic                   o_ready,
    input  pe_types_pkg::acc_vec_t i_data,
    output logic                   o_valid,
    input  logic                   i_ready,
    output pe_types_pkg::acc_vec_t o_data
);
    import pe_cfg_pkg::*;
    import pe_types_pkg::*;

    acc_vec_t           mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               push;
    logic               pop;

    function automatic logic [FIFO_AW-1:0] next_ptr(input logic [FIFO_AW-1:0] ptr);
        return (ptr == FIFO_AW'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign o_ready = count != CNT_W'(FIFO_DEPTH);
    assign o_valid = count != '0;
    assign push    = i_valid && o_ready;
    assign pop     = o_valid && i_ready;
    assign o_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (!push && pop) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== hw/channel_mac.sv ====
`timescale 1ns/10ps

module channel_mac (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_in_valid,
    output logic                   o_in_ready,
    input  pe_types_pkg::window_t  i_window,
    weight_if.mac                  wif,
    output logic                   o_acc_valid,
    input  logic                   i_acc_ready,
    output pe_types_pkg::acc_vec_t o_acc_data,
    input  logic                   i_fifo_pop
);
    import pe_cfg_pkg::*;
    import pe_types_pkg::*;

    pixel_t [KERNEL_PTS-1:0] slice [IN_CHANNEL];
    pixel_t [KERNEL_PTS-1:0] slice_q;
    logic [CH_W-1:0]         ch_cnt;
    logic                    busy;
    logic                    ch_last;
    logic                    accept;
    logic [CNT_W-1:0]        credits;
    logic [2:0]              pipe_v;
    logic [2:0]              pipe_first;
    logic [2:0]              pipe_last;
    dot_t                    dot_q [OUT_CHANNEL];
    logic signed [35:0]      prod_q [OUT_CHANNEL];

    function automatic dot_t dot_window(input pixel_t [KERNEL_PTS-1:0] px,
                                        input weight_t [KERNEL_PTS-1:0] wt);
        logic signed [15:0] prod;
        dot_t               sum;
        sum = '0;
        for (int p = 0; p < KERNEL_PTS; p++) begin
            prod = px[p] * wt[p];
            sum  = sum + prod;
        end
        return sum;
    endfunction

    assign ch_last          = ch_cnt == CH_W'(IN_CHANNEL - 1);
    assign o_in_ready       = !busy && (credits != CNT_W'(FIFO_DEPTH));
    assign accept           = i_in_valid && o_in_ready;
    assign wif.kern_rd_addr = ch_cnt;

    ////////////////////////////////////////
    // Channel sequencer and credits
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            ch_cnt  <= '0;
            credits <= '0;
        end else begin
            if (accept) begin
                busy   <= 1'b1;
                ch_cnt <= '0;
            end else if (busy) begin
                busy   <= !ch_last;
                ch_cnt <= ch_last ? '0 : ch_cnt + 1'b1;
            end
            // One credit per window until popped from the FIFO
            if (accept && !i_fifo_pop) begin
                credits <= credits + 1'b1;
            end else if (!accept && i_fifo_pop) begin
                credits <= credits - 1'b1;
            end
        end
    end

    // Window capture, channel slices move down one per step
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int c = 0; c < IN_CHANNEL; c++) begin
                for (int p = 0; p < KERNEL_PTS; p++) begin
                    slice[c][p] <= i_window[8*(p*IN_CHANNEL+c) +: 8];
                end
            end
        end else if (busy) begin
            for (int c = 0; c < IN_CHANNEL - 1; c++) begin
                slice[c] <= slice[c+1];
            end
        end
        // Lines up with the registered kernel read
        if (busy) begin
            slice_q <= slice[0];
        end
    end

    ////////////////////////////////////////
    // Dot product, coefficient, accumulate
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pipe_v      <= '0;
            pipe_first  <= '0;
            pipe_last   <= '0;
            o_acc_valid <= 1'b0;
        end else begin
            pipe_v     <= {pipe_v[1:0], busy};
            pipe_first <= {pipe_first[1:0], busy && (ch_cnt == '0)};
            pipe_last  <= {pipe_last[1:0], busy && ch_last};
            if (pipe_v[2] && pipe_last[2]) begin
                o_acc_valid <= 1'b1;
            end else if (i_acc_ready) begin
                o_acc_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < OUT_CHANNEL; o++) begin
            if (pipe_v[0]) begin
                dot_q[o] <= dot_window(slice_q, wif.kern_rd_data[o*KERNEL_PTS +: KERNEL_PTS]);
            end
            if (pipe_v[1]) begin
                prod_q[o] <= dot_q[o] * wif.coeff;
            end
            // Channel 0 starts from bias << 8
            if (pipe_v[2]) begin
                o_acc_data[o] <= (pipe_first[2] ? (acc_t'(signed'(wif.bias[o])) <<< 8)
                                                : o_acc_data[o]) + prod_q[o];
            end
        end
    end

endmodule

// ==== hw/conv_pe_top.sv ====
`timescale 1ns/10ps

module conv_pe_top (
    input  logic                            clk,
    input  logic                            rst_n,
    // Weight write port
    input  logic                            i_wr_en,
    input  logic [pe_types_pkg::ADDR_W-1:0] i_wr_addr,
    input  pe_types_pkg::wdata_u            i_wr_data,
    // Window input
    input  logic                            i_in_valid,
    output logic                            o_in_ready,
    input  pe_types_pkg::window_t           i_window,
    // Result output
    output logic                            o_out_valid,
    input  logic                            i_out_ready,
    output pe_types_pkg::result_vec_t       o_out_data
);
    import pe_types_pkg::*;

    logic signed [15:0] layer_scale;
    logic               acc_valid;
    logic               acc_ready;
    acc_vec_t           acc_data;
    logic               fifo_valid;
    logic               fifo_ready;
    logic               fifo_pop;
    acc_vec_t           fifo_data;

    weight_if u_wif ();

    // Pops return credits to the MAC
    assign fifo_pop = fifo_valid && fifo_ready;

    weight_store u_store (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_wr_en       (i_wr_en),
        .i_wr_addr     (i_wr_addr),
        .i_wr_data     (i_wr_data),
        .wif           (u_wif.store),
        .o_layer_scale (layer_scale)
    );

    channel_mac u_mac (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_in_valid  (i_in_valid),
        .o_in_ready  (o_in_ready),
        .i_window    (i_window),
        .wif         (u_wif.mac),
        .o_acc_valid (acc_valid),
        .i_acc_ready (acc_ready),
        .o_acc_data  (acc_data),
        .i_fifo_pop  (fifo_pop)
    );

    acc_fifo u_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (acc_valid),
        .o_ready (acc_ready),
        .i_data  (acc_data),
        .o_valid (fifo_valid),
        .i_ready (fifo_ready),
        .o_data  (fifo_data)
    );

    dequant_stage u_dequant (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_valid       (fifo_valid),
        .o_ready       (fifo_ready),
        .i_data        (fifo_data),
        .i_layer_scale (layer_scale),
        .o_valid       (o_out_valid),
        .i_ready       (i_out_ready),
        .o_data        (o_out_data)
    );

endmodule

// ==== hw/dequant_stage.sv ====
`timescale 1ns/10ps

module dequant_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_valid,
    output logic                      o_ready,
    input  pe_types_pkg::acc_vec_t    i_data,
    input  logic signed [15:0]        i_layer_scale,
    output logic                      o_valid,
    input  logic                      i_ready,
    output pe_types_pkg::result_vec_t o_data
);
    import pe_cfg_pkg::*;
    import pe_types_pkg::*;

    logic signed [23:0] sat_val [OUT_CHANNEL];
    logic signed [39:0] scaled_q [OUT_CHANNEL];
    logic               accept;

    // Take a new sum when the output register is empty or draining
    assign o_ready = !o_valid || i_ready;
    assign accept  = i_valid && o_ready;

    ////////////////////////////////////////
    // Saturate to 8 integer bits
    ////////////////////////////////////////

    always_comb begin
        for (int o = 0; o < OUT_CHANNEL; o++) begin
            if ((i_data[o] >>> FRAC_BITS) >= INT_MAX) begin
                sat_val[o] = 24'(INT_MAX << FRAC_BITS);
            end else if ((i_data[o] >>> FRAC_BITS) <= INT_MIN) begin
                sat_val[o] = 24'(INT_MIN << FRAC_BITS);
            end else begin
                sat_val[o] = i_data[o][23:0];
            end
        end
    end

    // Layer scale, product is Q8.32
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int o = 0; o < OUT_CHANNEL; o++) begin
                scaled_q[o] <= sat_val[o] * i_layer_scale;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_valid <= 1'b0;
        end else if (accept) begin
            o_valid <= 1'b1;
        end else if (i_ready) begin
            o_valid <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // Round to 16 bits
    ////////////////////////////////////////

    always_comb begin
        for (int o = 0; o < OUT_CHANNEL; o++) begin
            o_data[o] = scaled_q[o][39:24] + 16'(scaled_q[o][23] & (|scaled_q[o][22:20]));
        end
    end

endmodule

// ==== hw/pe_cfg_pkg.sv ====
package pe_cfg_pkg;

    // Layer shape
    localparam int IN_CHANNEL  = 3;
    localparam int OUT_CHANNEL = 4;
    localparam int KERNEL_PTS  = 9;
    localparam int KERN_WORDS  = OUT_CHANNEL * KERNEL_PTS;
    localparam int NUM_KERN    = KERN_WORDS * IN_CHANNEL;

    // Weight address map
    localparam int KERNEL_BASE_ADDR = 23;
    localparam int BIAS_BASE_ADDR   = KERNEL_BASE_ADDR + NUM_KERN;
    localparam int MACC_COEFF_ADDR  = BIAS_BASE_ADDR + OUT_CHANNEL;
    localparam int LAYER_SCALE_ADDR = MACC_COEFF_ADDR + 1;

    localparam int FIFO_DEPTH = 4;

    // Derived index widths
    localparam int CH_W    = $clog2(IN_CHANNEL);
    localparam int OC_W    = $clog2(OUT_CHANNEL);
    localparam int KOFF_W  = $clog2(NUM_KERN);
    localparam int KWORD_W = $clog2(KERN_WORDS);
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);
    localparam int CNT_W   = $clog2(FIFO_DEPTH + 1);

endpackage

// ==== hw/pe_types_pkg.sv ====
package pe_types_pkg;

    localparam int ADDR_W    = 32;
    // Accumulator holds 16 fraction bits
    localparam int FRAC_BITS = 16;
    localparam int INT_MAX   = 127;
    localparam int INT_MIN   = -128;

    typedef logic signed [7:0] pixel_t;
    typedef logic signed [7:0] weight_t;

    // Byte p*IN_CHANNEL+c is point p of channel c
    typedef logic [8*pe_cfg_pkg::KERNEL_PTS*pe_cfg_pkg::IN_CHANNEL-1:0] window_t;

    // Write word, full word for bias/coeff/scale or a kernel byte
    typedef union packed {
        logic signed [15:0] word;
        struct packed {
            logic [7:0] pad;
            weight_t    kern;
        } kern_v;
    } wdata_u;

    typedef logic signed [19:0] dot_t;
    typedef logic signed [39:0] acc_t;
    typedef logic signed [15:0] res_t;

    typedef acc_t [pe_cfg_pkg::OUT_CHANNEL-1:0] acc_vec_t;
    typedef res_t [pe_cfg_pkg::OUT_CHANNEL-1:0] result_vec_t;

endpackage

// ==== hw/weight_if.sv ====
`timescale 1ns/10ps

interface weight_if;
    import pe_cfg_pkg::*;
    import pe_types_pkg::*;

    // Input channel index, data follows one cycle later
    logic [CH_W-1:0]              kern_rd_addr;
    weight_t [KERN_WORDS-1:0]     kern_rd_data;
    logic [OUT_CHANNEL-1:0][15:0] bias;
    logic signed [15:0]           coeff;

    modport store (
        input  kern_rd_addr,
        output kern_rd_data,
        output bias,
        output coeff
    );

    modport mac (
        output kern_rd_addr,
        input  kern_rd_data,
        input  bias,
        input  coeff
    );

endinterface

// ==== hw/weight_store.sv ====
`timescale 1ns/10ps

module weight_store (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            i_wr_en,
    input  logic [pe_types_pkg::ADDR_W-1:0] i_wr_addr,
    input  pe_types_pkg::wdata_u            i_wr_data,
    weight_if.store                         wif,
    output logic signed [15:0]              o_layer_scale
);
    import pe_cfg_pkg::*;
    import pe_types_pkg::*;

    // One row per input channel, all output channels and points
    weight_t [KERN_WORDS-1:0] kern_ram [IN_CHANNEL];

    logic [ADDR_W-1:0]  kern_off;
    logic [ADDR_W-1:0]  bias_off;
    logic [KWORD_W-1:0] kern_word;
    logic [CH_W-1:0]    kern_ch;
    logic               kern_wr;
    logic               bias_wr;
    logic               coeff_wr;
    logic               scale_wr;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////

    assign kern_off = i_wr_addr - ADDR_W'(KERNEL_BASE_ADDR);
    assign bias_off = i_wr_addr - ADDR_W'(BIAS_BASE_ADDR);

    // offset = word*IN_CHANNEL + channel
    assign kern_word = KWORD_W'(kern_off[KOFF_W-1:0] / IN_CHANNEL);
    assign kern_ch   = CH_W'(kern_off[KOFF_W-1:0] % IN_CHANNEL);

    assign kern_wr  = i_wr_en && (i_wr_addr >= ADDR_W'(KERNEL_BASE_ADDR))
                              && (i_wr_addr < ADDR_W'(BIAS_BASE_ADDR));
    assign bias_wr  = i_wr_en && (i_wr_addr >= ADDR_W'(BIAS_BASE_ADDR))
                              && (i_wr_addr < ADDR_W'(BIAS_BASE_ADDR + OUT_CHANNEL));
    assign coeff_wr = i_wr_en && (i_wr_addr == ADDR_W'(MACC_COEFF_ADDR));
    assign scale_wr = i_wr_en && (i_wr_addr == ADDR_W'(LAYER_SCALE_ADDR));

    ////////////////////////////////////////
    // Kernel RAM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (kern_wr) begin
            kern_ram[kern_ch][kern_word] <= i_wr_data.kern_v.kern;
        end
        // Registered read
        wif.kern_rd_data <= kern_ram[wif.kern_rd_addr];
    end

    // Bias, coefficient and layer scale
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wif.bias      <= '0;
            wif.coeff     <= '0;
            o_layer_scale <= '0;
        end else begin
            if (bias_wr) begin
                wif.bias[bias_off[OC_W-1:0]] <= i_wr_data.word;
            end
            if (coeff_wr) begin
                wif.coeff <= i_wr_data.word;
            end
            if (scale_wr) begin
                o_layer_scale <= i_wr_data.word;
            end
        end
    end

endmodule

// ==== tests/conv_pe_tb.sv ====
`timescale 1ns/10ps

module conv_pe_tb;
    import pe_cfg_pkg::*;
    import pe_types_pkg::*;

    localparam logic [31:0] SEED        = 32'ha988;
    localparam int          MAX_RECS    = 64;
    localparam int          READY_LIMIT = 200;
    localparam int          DRAIN_LIMIT = 1000;

    logic               clk;
    logic               rst_n;
    logic               i_wr_en;
    logic [ADDR_W-1:0]  i_wr_addr;
    wdata_u             i_wr_data;
    logic               i_in_valid;
    logic               o_in_ready;
    window_t            i_window;
    logic               o_out_valid;
    logic               i_out_ready;
    result_vec_t        o_out_data;

    // Records {kind, a, b} as laid out in tests/pe_input.dat
    logic [99:0]        recs [MAX_RECS];

    // Reference model state
    logic signed [7:0]  m_kern [NUM_KERN];
    logic signed [15:0] m_bias [OUT_CHANNEL];
    logic signed [15:0] m_coeff;
    logic signed [15:0] m_scale;

    logic [63:0]        exp_q [$];
    logic [31:0]        pix_state;
    logic [31:0]        bp_state;
    logic               bp_en;
    int                 bp_left;
    int                 stall_max;
    int                 errors;
    int                 err_mark;
    int                 checks;
    int                 tests_run;
    int                 tests_failed;

    tb_clock_gen #(.PERIOD_NS(20)) u_clk (.o_clk(clk));

    conv_pe_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_wr_en     (i_wr_en),
        .i_wr_addr   (i_wr_addr),
        .i_wr_data   (i_wr_data),
        .i_in_valid  (i_in_valid),
        .o_in_ready  (o_in_ready),
        .i_window    (i_window),
        .o_out_valid (o_out_valid),
        .i_out_ready (i_out_ready),
        .o_out_data  (o_out_data)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] addr_fold(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24];
    endfunction

    function automatic string test_name(input int num);
        case (num)
            1:       return "directed windows";
            2:       return "kernel address decode";
            3:       return "saturation";
            4:       return "streaming";
            5:       return "back-pressure";
            6:       return "unmapped writes";
            default: return "unnamed";
        endcase
    endfunction

    function automatic window_t random_window();
        window_t w;
        for (int i = 0; i < KERNEL_PTS * IN_CHANNEL; i++) begin
            pix_state    = xorshift32(pix_state);
            w[8*i +: 8] = pix_state[15:8];
        end
        return w;
    endfunction

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic logic [63:0] model_result(input window_t w);
        logic signed [39:0] acc;
        logic signed [39:0] dot;
        logic signed [7:0]  px;
        logic signed [23:0] sat;
        logic signed [39:0] scaled;
        logic [63:0]        res;
        for (int o = 0; o < OUT_CHANNEL; o++) begin
            acc = m_bias[o];
            acc = acc <<< 8;
            for (int c = 0; c < IN_CHANNEL; c++) begin
                dot = 0;
                for (int p = 0; p < KERNEL_PTS; p++) begin
                    px  = w[8*(p*IN_CHANNEL+c) +: 8];
                    dot = dot + px * m_kern[(o*KERNEL_PTS+p)*IN_CHANNEL+c];
                end
                acc = acc + dot * m_coeff;
            end
            // Integer part limited to 8 bits
            if ((acc >>> 16) > 126) begin
                sat = 24'sh7f_0000;
            end else if ((acc >>> 16) < -127) begin
                sat = 24'sh80_0000;
            end else begin
                sat = acc[23:0];
            end
            scaled = sat * m_scale;
            res[16*o +: 16] = scaled[39:24] + {15'd0, scaled[23] & (scaled[22:20] != 3'd0)};
        end
        return res;
    endfunction

    ////////////////////////////////////////
    // Checks and waits
    ////////////////////////////////////////

    task automatic abort_run(input string what);
        $display("Timeout: %s", what);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR t=%0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited <= DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            abort_run("results still outstanding on the output");
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic write_weight(input logic [31:0] addr, input logic [15:0] data);
        wait_drained();
        i_wr_en        = 1'b1;
        i_wr_addr      = addr;
        i_wr_data.word = data;
        if (addr >= KERNEL_BASE_ADDR && addr < BIAS_BASE_ADDR) begin
            m_kern[addr - KERNEL_BASE_ADDR] = data[7:0];
        end else if (addr >= BIAS_BASE_ADDR && addr < BIAS_BASE_ADDR + OUT_CHANNEL) begin
            m_bias[addr - BIAS_BASE_ADDR] = data;
        end else if (addr == MACC_COEFF_ADDR) begin
            m_coeff = data;
        end else if (addr == LAYER_SCALE_ADDR) begin
            m_scale = data;
        end
        @(negedge clk);
        i_wr_en = 1'b0;
    endtask

    // Byte per kernel address from the folded address
    task automatic fill_kernel(input logic [7:0] mul, input logic [7:0] add);
        logic [7:0] value;
        for (int a = KERNEL_BASE_ADDR; a < BIAS_BASE_ADDR; a++) begin
            value = addr_fold(a) * mul + add;
            write_weight(a, {8'h00, value});
        end
    endtask

    task automatic send_window(input window_t w);
        int waited;
        waited     = 0;
        i_in_valid = 1'b1;
        i_window   = w;
        while (!o_in_ready && waited <= READY_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!o_in_ready) begin
            abort_run("o_in_ready stayed low");
        end
        if (waited > stall_max) begin
            stall_max = waited;
        end
        @(negedge clk);
        i_in_valid = 1'b0;
    endtask

    task automatic send_directed(input logic [7:0] pix, input logic [63:0] expected);
        logic [63:0] predicted;
        predicted = model_result({(KERNEL_PTS*IN_CHANNEL){pix}});
        for (int o = 0; o < OUT_CHANNEL; o++) begin
            check_value($sformatf("reference[%0d]", o), expected[16*o +: 16],
                        predicted[16*o +: 16]);
        end
        exp_q.push_back(expected);
        send_window({(KERNEL_PTS*IN_CHANNEL){pix}});
    endtask

    task automatic run_random(input int count, input logic bp);
        window_t w;
        stall_max = 0;
        bp_en     = bp;
        for (int n = 0; n < count; n++) begin
            w = random_window();
            exp_q.push_back(model_result(w));
            send_window(w);
        end
        // Busy sweep alone holds o_in_ready low for IN_CHANNEL cycles
        if (bp && stall_max <= IN_CHANNEL) begin
            errors++;
            $display("o_in_ready never dropped while the output was stalled");
        end
    endtask

    task automatic finish_test(input int num);
        wait_drained();
        bp_en = 1'b0;
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
        end
        $display("test %0d (%s): %s", num, test_name(num),
                 (errors == err_mark) ? "passed" : "failed");
        err_mark = errors;
    endtask

    ////////////////////////////////////////
    // Output side
    ////////////////////////////////////////

    always @(negedge clk) begin : out_monitor
        logic [63:0] expected;
        logic [63:0] got;
        if (bp_en) begin
            if (bp_left == 0) begin
                bp_state    = xorshift32(bp_state);
                i_out_ready = !i_out_ready;
                // Long low stretches, short high ones
                bp_left     = i_out_ready ? 1 + bp_state[2:0] : 8 + bp_state[4:0];
            end else begin
                bp_left--;
            end
        end else begin
            i_out_ready = 1'b1;
        end
        // Transfer happens on the coming rising edge
        if (o_out_valid && i_out_ready) begin
            got = o_out_data;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected result at %0t with no window outstanding", $time);
            end else begin
                expected = exp_q.pop_front();
                for (int o = 0; o < OUT_CHANNEL; o++) begin
                    check_value($sformatf("o_out_data[%0d]", o), expected[16*o +: 16],
                                got[16*o +: 16]);
                end
            end
        end
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin : main
        int          idx;
        logic [3:0]  kind;
        logic [31:0] a;
        logic [63:0] b;
        rst_n       = 1'b0;
        i_wr_en     = 1'b0;
        i_wr_addr   = '0;
        i_wr_data   = '0;
        i_in_valid  = 1'b0;
        i_window    = '0;
        i_out_ready = 1'b1;
        pix_state   = SEED;
        bp_state    = xorshift32(SEED);
        bp_en       = 1'b0;
        bp_left     = 0;
        stall_max   = 0;
        errors      = 0;
        err_mark    = 0;
        checks      = 0;
        tests_run   = 0;
        tests_failed = 0;
        m_coeff     = '0;
        m_scale     = '0;
        for (int o = 0; o < OUT_CHANNEL; o++) begin
            m_bias[o] = '0;
        end
        for (idx = 0; idx < MAX_RECS; idx++) begin
            recs[idx] = '0;
        end
        $readmemh("tests/pe_input.dat", recs);

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Idle state after reset
        check_value("o_in_ready", 16'd1, {15'd0, o_in_ready});
        check_value("o_out_valid", 16'd0, {15'd0, o_out_valid});

        idx = 0;
        while (idx < MAX_RECS && recs[idx][99:96] != 4'h0) begin
            {kind, a, b} = recs[idx];
            case (kind)
                4'h1:    write_weight(a, b[15:0]);
                4'h2:    fill_kernel(b[15:8], b[7:0]);
                4'h3:    send_directed(a[7:0], b);
                4'h4:    run_random(a, b[0]);
                4'h5:    finish_test(a);
                default: begin
                    errors++;
                    $display("Unknown record kind %h in stimulus line %0d", kind, idx);
                end
            endcase
            idx++;
        end

        // Catch late or duplicated results
        repeat (20) @(negedge clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d results never arrived", exp_q.size());
        end
        if (tests_run == 0) begin
            errors++;
            $display("No tests found in the stimulus file");
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== tests/pe_input.dat ====
// One record per line, kind_a_b in hex (1, 8 and 16 digits)
// 1 write a=addr b=data, 2 kernel fill b={mul,add}, 3 window a=pixel b={o3,o2,o1,o0}
// 4 random windows a=count b=back-pressure, 5 end of test a=test number
2_00000000_0000000000000001
1_00000083_0000000000000004
1_00000084_0000000000000008
1_00000085_000000000000FFFC
1_00000086_0000000000000000
1_00000087_0000000000001000
1_00000088_0000000000004000
3_00000001_006C006B006E006D
3_000000FE_FF28FF27FF2AFF29
3_00000005_021C021B021E021D
5_00000001_0000000000000000
2_00000000_0000000000002503
1_00000087_0000000000000010
4_00000006_0000000000000000
5_00000002_0000000000000000
2_00000000_0000000000000001
1_00000083_0000000000007FFF
1_00000084_0000000000008000
1_00000085_0000000000000000
1_00000087_0000000000007FFF
3_00000001_03600360E3601FC0
3_000000FF_FCA0FCA0E0001CA0
4_00000004_0000000000000000
5_00000003_0000000000000000
2_00000000_0000000000000B81
1_00000087_0000000000000020
4_00000020_0000000000000000
5_00000004_0000000000000000
4_00000030_0000000000000001
5_00000005_0000000000000000
2_00000000_0000000000000001
1_00000087_0000000000007FFF
1_00000016_0000000000005A5A
1_000000C8_0000000000005A5A
1_80000087_0000000000005A5A
3_00000001_03600360E3601FC0
5_00000006_0000000000000000

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) o_clk = ~o_clk;
        end
    end

endmodule
